//--- verif/can_frame_patterns.txt
# prescaler dlc role error_bit
# role: 0 receive, 1 transmit, 2 both; error_bit: -1 none, else bit time after SOF
0 0 0 -1
1 8 1 -1
3 2 2 -1
2 10 0 -1
0 0 1 0
1 3 0 5
0 8 2 20
2 1 1 12
0 5 0 46
1 0 2 46
0 2 1 30
3 4 0 2
0 6 1 60
1 1 2 9
0 8 0 109
2 3 1 33
0 0 0 1
1 7 2 70
0 2 1 15
0 4 0 40
1 1 1 -1
0 2 2 -1

//--- files.f
+incdir+include
logic/can_frame_pkg.sv
logic/can_reg_pkg.sv
logic/can_ctrl_regs.sv
logic/can_bit_timer.sv
logic/can_frame_sequencer.sv
logic/can_error_counter.sv
logic/can_frame_top.sv
verif/can_frame_tb.sv

//--- Makefile
TOP := can_frame_tb
LOG := sim.log
RTL := logic/can_frame_pkg.sv logic/can_reg_pkg.sv logic/can_ctrl_regs.sv \
       logic/can_bit_timer.sv logic/can_frame_sequencer.sv \
       logic/can_error_counter.sv logic/can_frame_top.sv

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): files.f include/can_settings.svh $(RTL) verif/can_frame_tb.sv
	verilator --binary --timing --top-module $(TOP) -f files.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Simulation finished: PASS$$" $(LOG)

lint:
	verilator --lint-only -Wall +incdir+include --top-module can_frame_top $(RTL)

clean:
	rm -rf obj_dir $(LOG)

//--- verif/can_frame_tb.sv
// Self-checking testbench for the CAN frame top level; runs the frame tests of the pattern file.
`timescale 1ns/1ns
`include "can_settings.svh"

module can_frame_tb
  import can_frame_pkg::*;
  import can_reg_pkg::*;
();

  logic                          clk;
  logic                          rst_n;
  logic                          reg_wr;
  logic [1:0]                    reg_addr;
  logic [`CAN_REG_WIDTH-1:0]     reg_wdata;
  logic [`CAN_REG_WIDTH-1:0]     reg_rdata;
  logic                          rx_start;
  logic                          tx_request;
  logic                          error_detected;
  logic [3:0]                    state;
  logic                          tx_active;
  logic                          rx_active;
  logic                          frame_done;
  logic [`CAN_ERR_CNT_WIDTH-1:0] err_count;
  logic                          error_passive;

  int     pat_presc[$];
  int     pat_dlc[$];
  int     pat_role[$];
  int     pat_err[$];
  int     errors = 0;
  int     done_cnt = 0;
  int     cycle_cnt = 0;
  int     limit = 0;
  int     cnt_model = 0;
  integer seed = 32'hc059;

  can_frame_top u_dut (.*);

  always #20 clk = ~clk;

  // A pulse lasts one full cycle, so each falling edge sees it once.
  always @(negedge clk) begin
    if (frame_done) done_cnt++;
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > limit) begin
      $display("Timeout: the frame tests did not finish within %0d clock cycles.", limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  task automatic report_mismatch(input string name, input int expected, input int actual);
    $display("[ERROR] %0t ns %s expected %0d actual %0d", $time, name, expected, actual);
    errors++;
  endtask

  task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_wr = 1'b0;
  endtask

  // Field order of a frame without errors.
  function automatic logic [3:0] next_field(input logic [3:0] cur, input int dlc);
    case (cur)
      SOF:         return ARBITRATION;
      ARBITRATION: return CONTROL;
      CONTROL:     return (dlc == 0) ? CRC : DATA;  // No data bytes.
      DATA:        return CRC;
      CRC:         return ACK;
      ACK:         return EOF;
      EOF:         return IFS;
      default:     return IDLE;
    endcase
  endfunction

  task automatic check_roles(input int role, input logic in_frame);
    logic exp_tx;
    logic exp_rx;
    exp_tx = in_frame && (role != 0);  // Transmit wins when both are requested.
    exp_rx = in_frame && (role == 0);
    if (tx_active != exp_tx) report_mismatch("tx_active", int'(exp_tx), int'(tx_active));
    if (rx_active != exp_rx) report_mismatch("rx_active", int'(exp_rx), int'(rx_active));
  endtask

  task automatic check_counter();
    logic exp_passive;
    exp_passive = (cnt_model >= `CAN_ERR_PASSIVE_LIMIT);
    if (int'(err_count) != cnt_model) report_mismatch("err_count", cnt_model, int'(err_count));
    if (error_passive != exp_passive) begin
      report_mismatch("error_passive", int'(exp_passive), int'(error_passive));
    end
  endtask

  task automatic check_registers();
    reg_addr = REG_STATUS;
    @(negedge clk);
    if (reg_rdata != 16'h0000) report_mismatch("reg_rdata", 0, int'(reg_rdata));
    write_reg(REG_TIMING, 16'h805a);
    write_reg(REG_FRAME, 16'h000c);  // Above the largest dlc.
    reg_addr = REG_TIMING;
    @(negedge clk);
    if (reg_rdata != 16'h805a) report_mismatch("reg_rdata", 32'h805a, int'(reg_rdata));
    reg_addr = REG_FRAME;
    @(negedge clk);
    if (reg_rdata != 16'h0008) report_mismatch("reg_rdata", 8, int'(reg_rdata));
  endtask

  task automatic load_patterns();
    int    fd;
    int    n;
    int    presc;
    int    dlc;
    int    role;
    int    err_bit;
    string line;
    fd = $fopen("verif/can_frame_patterns.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) != 0) begin
        n = $sscanf(line, "%d %d %d %d", presc, dlc, role, err_bit);
        if (n == 4) begin  // Comment lines scan no fields.
          pat_presc.push_back(presc);
          pat_dlc.push_back(dlc);
          pat_role.push_back(role);
          pat_err.push_back(err_bit);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_frame(input int presc, input int dlc, input int role, input int err_bit);
    logic [3:0] prev;
    int         eff_dlc;
    int         exp_len;
    int         exp_done;
    int         cycles;
    int         done_before;
    eff_dlc = (dlc > `CAN_MAX_DLC) ? `CAN_MAX_DLC : dlc;
    exp_len = (47 + 8 * eff_dlc) * (presc + 1);
    write_reg(REG_TIMING, {1'b0, 7'd0, presc[7:0]});  // Disabling reloads the prescaler.
    write_reg(REG_TIMING, {1'b1, 7'd0, presc[7:0]});
    write_reg(REG_FRAME, {12'd0, dlc[3:0]});
    repeat ({$random(seed)} % 16) @(negedge clk);
    check_roles(role, 1'b0);
    done_before = done_cnt;
    tx_request  = (role != 0);
    rx_start    = (role != 1);
    do begin
      @(negedge clk);
    end while (state != SOF);
    tx_request = 1'b0;
    rx_start   = 1'b0;
    check_roles(role, 1'b1);
    if (err_bit < 0) begin
      exp_done = 1;
      cycles   = 0;
      prev     = state;
      while (state != IDLE) begin
        @(negedge clk);
        cycles++;
        if (state != prev) begin
          if (state != next_field(prev, eff_dlc)) begin
            report_mismatch("state", int'(next_field(prev, eff_dlc)), int'(state));
          end
          check_roles(role, state != IDLE);
          prev = state;
        end
      end
      if (cycles != exp_len) report_mismatch("frame cycles", exp_len, cycles);
      if (cnt_model > 0) cnt_model--;
    end else begin
      exp_done = 0;
      repeat (err_bit * (presc + 1)) @(negedge clk);
      error_detected = 1'b1;
      @(negedge clk);
      error_detected = 1'b0;
      @(negedge clk);
      if (state != ERROR) report_mismatch("state", int'(ERROR), int'(state));
      check_roles(role, 1'b0);
      repeat (8 * (presc + 1)) @(negedge clk);
      if (state != IDLE) report_mismatch("state", int'(IDLE), int'(state));
      cnt_model = (cnt_model + `CAN_ERR_INC > 255) ? 255 : cnt_model + `CAN_ERR_INC;
    end
    repeat (2) @(negedge clk);  // Count settles a cycle after the pulse.
    if (done_cnt - done_before != exp_done) begin
      report_mismatch("frame_done pulses", exp_done, done_cnt - done_before);
    end
    check_counter();
  endtask

  initial begin
    clk            = 1'b0;
    rst_n          = 1'b0;
    reg_wr         = 1'b0;
    reg_addr       = 2'd0;
    reg_wdata      = '0;
    rx_start       = 1'b0;
    tx_request     = 1'b0;
    error_detected = 1'b0;
    load_patterns();
    if (pat_presc.size() == 0) begin
      $display("No frame tests could be read from the pattern file.");
      $display("Simulation finished: FAIL");
      $finish;
    end else begin
      limit = 64;  // Reset and register access.
      foreach (pat_presc[k]) begin
        limit += (47 + 8 * `CAN_MAX_DLC + 8) * (pat_presc[k] + 1) + 64;
      end
      repeat (16) @(negedge clk);
      rst_n = 1'b1;
      check_registers();
      foreach (pat_presc[k]) begin
        run_frame(pat_presc[k], pat_dlc[k], pat_role[k], pat_err[k]);
      end
      $display("Frames run: %0d, errors: %0d", pat_presc.size(), errors);
      if (errors == 0) begin
        $display("Simulation finished: PASS");
      end else begin
        $display("Simulation finished: FAIL");
      end
      $finish;
    end
  end

endmodule

//--- logic/can_frame_top.sv
// Top level of the CAN frame sequencer: registers, bit timer, FSM and error counter.
`timescale 1ns/1ns
`include "can_settings.svh"

module can_frame_top
  import can_frame_pkg::*;
  import can_reg_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          reg_wr,
  input  logic [1:0]                    reg_addr,
  input  logic [`CAN_REG_WIDTH-1:0]     reg_wdata,
  output logic [`CAN_REG_WIDTH-1:0]     reg_rdata,
  input  logic                          rx_start,
  input  logic                          tx_request,
  input  logic                          error_detected,
  output logic [3:0]                    state,
  output logic                          tx_active,
  output logic                          rx_active,
  output logic                          frame_done,
  output logic [`CAN_ERR_CNT_WIDTH-1:0] err_count,
  output logic                          error_passive
);

  can_cfg_t          cfg;
  can_frame_status_t status;
  logic              bit_time;

  can_ctrl_regs u_regs (
    .clk           (clk),
    .rst_n         (rst_n),
    .reg_wr        (reg_wr),
    .reg_addr      (can_reg_addr_e'(reg_addr)),
    .reg_wdata     (reg_wdata),
    .status        (status),
    .err_count     (err_count),
    .error_passive (error_passive),
    .cfg           (cfg),
    .reg_rdata     (reg_rdata)
  );

  can_bit_timer u_timer (
    .clk      (clk),
    .rst_n    (rst_n),
    .cfg      (cfg),
    .bit_time (bit_time)
  );

  can_frame_sequencer u_seq (
    .clk            (clk),
    .rst_n          (rst_n),
    .bit_time       (bit_time),
    .dlc            (cfg.dlc),
    .rx_start       (rx_start),
    .tx_request     (tx_request),
    .error_detected (error_detected),
    .status         (status)
  );

  can_error_counter u_errcnt (
    .clk           (clk),
    .rst_n         (rst_n),
    .status        (status),
    .err_count     (err_count),
    .error_passive (error_passive)
  );

  assign state      = status.state;
  assign tx_active  = status.tx_active;
  assign rx_active  = status.rx_active;
  assign frame_done = status.frame_done;

endmodule

//--- logic/can_error_counter.sv
// Saturating frame error counter that flags the error-passive condition.
`timescale 1ns/1ns
`include "can_settings.svh"

module can_error_counter
  import can_frame_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  can_frame_status_t             status,
  output logic [`CAN_ERR_CNT_WIDTH-1:0] err_count,
  output logic                          error_passive
);

  localparam int W = `CAN_ERR_CNT_WIDTH;

  logic [W:0]   inc_sum;
  logic [W-1:0] cnt_next;

  assign inc_sum = {1'b0, err_count} + (W+1)'(`CAN_ERR_INC);

  always_comb begin
    cnt_next = err_count;
    if (status.error_entry) begin
      cnt_next = inc_sum[W] ? {W{1'b1}} : inc_sum[W-1:0];  // Clip at full scale.
    end else if (status.frame_done && err_count != '0) begin
      cnt_next = err_count - 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      err_count     <= '0;
      error_passive <= 1'b0;
    end else begin
      err_count     <= cnt_next;
      error_passive <= (cnt_next >= W'(`CAN_ERR_PASSIVE_LIMIT));  // Tracks the new count.
    end
  end

endmodule

//--- logic/can_frame_sequencer.sv
// Frame field FSM: walks SOF to IFS one field length at a time, with error override.
`timescale 1ns/1ns
`include "can_settings.svh"

module can_frame_sequencer
  import can_frame_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      bit_time,
  input  logic [`CAN_DLC_WIDTH-1:0] dlc,
  input  logic                      rx_start,
  input  logic                      tx_request,
  input  logic                      error_detected,
  output can_frame_status_t         status
);

  can_state_e   state;
  can_state_e   next_state;
  can_bit_cnt_t bit_cnt;
  can_bit_cnt_t field_len;
  can_bit_cnt_t data_len;
  logic         error_r;
  logic         tx_active;
  logic         rx_active;
  logic         frame_done;
  logic         error_entry;
  logic         field_last;
  logic         advance;

  assign data_len = {{(`CAN_BIT_CNT_WIDTH-`CAN_DLC_WIDTH-3){1'b0}}, dlc, 3'b000};

  // Length of the field being sent.
  always_comb begin
    case (state)
      SOF:         field_len = SOF_LEN;
      ARBITRATION: field_len = ARB_LEN;
      CONTROL:     field_len = CTRL_LEN;
      DATA:        field_len = data_len;
      CRC:         field_len = CRC_LEN;
      ACK:         field_len = ACK_LEN;
      EOF:         field_len = EOF_LEN;
      IFS:         field_len = IFS_LEN;
      ERROR:       field_len = ERROR_LEN;
      default:     field_len = '0;
    endcase
  end

  always_comb begin
    case (state)
      IDLE:        next_state = (tx_request || rx_start) ? SOF : IDLE;
      SOF:         next_state = ARBITRATION;
      ARBITRATION: next_state = CONTROL;
      CONTROL:     next_state = (data_len == '0) ? CRC : DATA;  // Empty data field.
      DATA:        next_state = CRC;
      CRC:         next_state = ACK;
      ACK:         next_state = EOF;
      EOF:         next_state = IFS;
      IFS:         next_state = IDLE;
      default:     next_state = IDLE;  // ERROR ends in IDLE.
    endcase
  end

  assign field_last = (bit_cnt == field_len - 1'b1);
  assign advance    = bit_time && ((state == IDLE) ? (tx_request || rx_start) : field_last);

  // The error input acts one cycle after it is sampled.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      error_r <= 1'b0;
    end else begin
      error_r <= error_detected;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= IDLE;
      bit_cnt     <= '0;
      tx_active   <= 1'b0;
      rx_active   <= 1'b0;
      frame_done  <= 1'b0;
      error_entry <= 1'b0;
    end else begin
      frame_done  <= 1'b0;
      error_entry <= 1'b0;
      if (error_r) begin
        state       <= ERROR;  // Restarts the error field if already there.
        bit_cnt     <= '0;
        tx_active   <= 1'b0;
        rx_active   <= 1'b0;
        error_entry <= (state != ERROR);
      end else if (advance) begin
        state   <= next_state;
        bit_cnt <= '0;
        if (state == IDLE) begin
          // Role is fixed at start of frame, transmit first.
          tx_active <= tx_request;
          rx_active <= !tx_request && rx_start;
        end else if (next_state == IDLE) begin
          tx_active  <= 1'b0;
          rx_active  <= 1'b0;
          frame_done <= (state == IFS);
        end
      end else if (bit_time && state != IDLE) begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end
  end

  assign status.state       = state;
  assign status.tx_active   = tx_active;
  assign status.rx_active   = rx_active;
  assign status.frame_done  = frame_done;
  assign status.error_entry = error_entry;

endmodule

//--- logic/can_bit_timer.sv
// Prescaled bit-time strobe generator feeding the frame sequencer.
`timescale 1ns/1ns
`include "can_settings.svh"

module can_bit_timer
  import can_reg_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  can_cfg_t cfg,
  output logic     bit_time
);

  logic [`CAN_PRESC_WIDTH-1:0] presc_cnt;

  // Counts down from the prescaler; zero marks the last cycle of a bit.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      presc_cnt <= '0;
    end else if (!cfg.bit_enable) begin
      presc_cnt <= cfg.prescaler;  // Hold at reload while disabled.
    end else if (presc_cnt == '0) begin
      presc_cnt <= cfg.prescaler;
    end else begin
      presc_cnt <= presc_cnt - 1'b1;
    end
  end

  // Prescaler 0 keeps the count at zero, so the strobe is high every cycle.
  assign bit_time = cfg.bit_enable && (presc_cnt == '0);

endmodule

//--- logic/can_ctrl_regs.sv
// Host register block: holds timing and frame setup and returns read data by address.
`timescale 1ns/1ns
`include "can_settings.svh"

module can_ctrl_regs
  import can_reg_pkg::*;
  import can_frame_pkg::*;
(
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          reg_wr,
  input  can_reg_addr_e                 reg_addr,
  input  can_reg_word_u                 reg_wdata,
  input  can_frame_status_t             status,
  input  logic [`CAN_ERR_CNT_WIDTH-1:0] err_count,
  input  logic                          error_passive,
  output can_cfg_t                      cfg,
  output logic [`CAN_REG_WIDTH-1:0]     reg_rdata
);

  localparam logic [`CAN_DLC_WIDTH-1:0] MAX_DLC = `CAN_MAX_DLC;

  logic [`CAN_DLC_WIDTH-1:0] wr_dlc;
  can_reg_word_u             rd_word;

  assign wr_dlc = (reg_wdata.frame.dlc > MAX_DLC) ? MAX_DLC : reg_wdata.frame.dlc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cfg <= '0;
    end else if (reg_wr) begin
      case (reg_addr)
        REG_TIMING: begin
          cfg.prescaler  <= reg_wdata.timing.prescaler;
          cfg.bit_enable <= reg_wdata.timing.enable;
        end
        REG_FRAME: cfg.dlc <= wr_dlc;
        default: ;  // Status is read only.
      endcase
    end
  end

  // Read mux.
  always_comb begin
    rd_word = '0;
    case (reg_addr)
      REG_TIMING: begin
        rd_word.timing.prescaler = cfg.prescaler;
        rd_word.timing.enable    = cfg.bit_enable;
      end
      REG_FRAME: rd_word.frame.dlc = cfg.dlc;
      REG_STATUS: begin
        rd_word[`CAN_ERR_CNT_WIDTH-1:0] = err_count;
        rd_word[8]                      = error_passive;
        rd_word[15:12]                  = status.state;
      end
      default: rd_word = '0;
    endcase
  end

  assign reg_rdata = rd_word;

endmodule

//--- logic/can_reg_pkg.sv
// Register map types of the CAN controller host interface, used by the register block.
`include "can_settings.svh"

package can_reg_pkg;

  typedef enum logic [1:0] {
    REG_TIMING = 2'd0,
    REG_FRAME  = 2'd1,
    REG_STATUS = 2'd2
  } can_reg_addr_e;

  // Timing register layout.
  typedef struct packed {
    logic                                          enable;     // Bit 15.
    logic [`CAN_REG_WIDTH-`CAN_PRESC_WIDTH-2:0]    reserved;
    logic [`CAN_PRESC_WIDTH-1:0]                   prescaler;  // Bits 7..0.
  } can_timing_view_t;

  // Frame register layout.
  typedef struct packed {
    logic [`CAN_REG_WIDTH-`CAN_DLC_WIDTH-1:0] reserved;
    logic [`CAN_DLC_WIDTH-1:0]                dlc;        // Bits 3..0.
  } can_frame_view_t;

  // One write word, read through the view that its address selects.
  typedef union packed {
    can_timing_view_t timing;
    can_frame_view_t  frame;
  } can_reg_word_u;

  // Configuration driven to the bit timer and the sequencer.
  typedef struct packed {
    logic [`CAN_PRESC_WIDTH-1:0] prescaler;
    logic                        bit_enable;
    logic [`CAN_DLC_WIDTH-1:0]   dlc;         // Already clamped to the largest dlc.
  } can_cfg_t;

endpackage

//--- logic/can_frame_pkg.sv
// Frame-level types and field lengths shared by the sequencer, the error counter and the top.
`include "can_settings.svh"

package can_frame_pkg;

  // Frame fields in transmission order.
  typedef enum logic [3:0] {
    IDLE        = 4'd0,
    SOF         = 4'd1,
    ARBITRATION = 4'd2,
    CONTROL     = 4'd3,
    DATA        = 4'd4,
    CRC         = 4'd5,
    ACK         = 4'd6,
    EOF         = 4'd7,
    IFS         = 4'd8,
    ERROR       = 4'd9
  } can_state_e;

  typedef logic [`CAN_BIT_CNT_WIDTH-1:0] can_bit_cnt_t;

  // Field lengths in bit times. DATA is 8 bits per byte of the dlc.
  localparam can_bit_cnt_t SOF_LEN   = 8'd1;
  localparam can_bit_cnt_t ARB_LEN   = 8'd12;
  localparam can_bit_cnt_t CTRL_LEN  = 8'd6;
  localparam can_bit_cnt_t CRC_LEN   = 8'd16;
  localparam can_bit_cnt_t ACK_LEN   = 8'd2;
  localparam can_bit_cnt_t EOF_LEN   = 8'd7;
  localparam can_bit_cnt_t IFS_LEN   = 8'd3;
  localparam can_bit_cnt_t ERROR_LEN = 8'd8;

  // Sequencer status seen by the error counter and the register block.
  typedef struct packed {
    can_state_e state;
    logic       tx_active;
    logic       rx_active;
    logic       frame_done;   // One cycle after IFS returns to IDLE.
    logic       error_entry;  // One cycle after ERROR is entered.
  } can_frame_status_t;

endpackage

//--- include/can_settings.svh
// Widths and limits of the CAN frame sequencer, included by the packages and the RTL.
`ifndef CAN_SETTINGS_SVH
`define CAN_SETTINGS_SVH

// Register word width of the host interface.
`define CAN_REG_WIDTH 16

// Bit-timing prescaler width.
`define CAN_PRESC_WIDTH 8

// Data length code field width and its largest legal value.
`define CAN_DLC_WIDTH 4
`define CAN_MAX_DLC 8

// Bit counter inside a frame field.
`define CAN_BIT_CNT_WIDTH 8

// Error counter width, step per error and error-passive threshold.
`define CAN_ERR_CNT_WIDTH 8
`define CAN_ERR_INC 8
`define CAN_ERR_PASSIVE_LIMIT 128

`endif
